//--- pixel_processing.f
+incdir+.
pixel_pkg.sv
pixel_source_select.sv
manual_lut_step.sv
fast_mono_step.sv
pixel_state_merge.sv
pixel_processing.sv
tb_pixel_processing.sv

//--- Makefile
TOOL     := verilator
TOP      := tb_pixel_processing
FILELIST := pixel_processing.f
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   list these targets"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- tb_pixel_processing.sv
// Testbench with random stimulus, reference model, checker and watchdog for the pixel engine
`timescale 1ns/1ps
`include "pixel_defs.svh"

module tb_pixel_processing;

    // Cycle budget per test that sizes the watchdog
    localparam int MANUAL_CYCLES  = 400;
    localparam int MONO_CYCLES    = 400;
    localparam int CMD_CYCLES     = 300;
    localparam int INIT_CYCLES    = 200;
    localparam int THRU_CYCLES    = 400;
    localparam int TOTAL_CYCLES   = 2 + 1 + MANUAL_CYCLES + MONO_CYCLES + CMD_CYCLES
                                  + INIT_CYCLES + THRU_CYCLES + 1;

    logic        clk;
    logic        reset;
    logic [5:0]  csr_lutframe;
    logic [1:0]  csr_mindrv;
    logic [3:0]  proc_p_or;
    logic [3:0]  proc_p_e4;
    logic        proc_p_bd;
    logic        proc_p_n1;
    logic [15:0] proc_bi;
    logic [1:0]  proc_lut_rd;
    logic [1:0]  op_state;
    logic        op_valid;
    logic [7:0]  op_cmd;
    logic [7:0]  op_param;
    logic [7:0]  op_framecnt;
    logic [15:0] proc_bo;
    logic [1:0]  proc_output;

    // Expected result waiting in the output register
    logic [15:0] pend_bo;
    logic [1:0]  pend_drv;
    string       pend_name;
    logic        pend_valid;
    int          error_count;
    int          check_count;

    pixel_processing UUT (
        .clk(clk), .reset(reset), .csr_lutframe(csr_lutframe), .csr_mindrv(csr_mindrv),
        .proc_p_or(proc_p_or), .proc_p_e4(proc_p_e4), .proc_p_bd(proc_p_bd),
        .proc_p_n1(proc_p_n1), .proc_bi(proc_bi), .proc_lut_rd(proc_lut_rd),
        .op_state(op_state), .op_valid(op_valid), .op_cmd(op_cmd), .op_param(op_param),
        .op_framecnt(op_framecnt), .proc_bo(proc_bo), .proc_output(proc_output)
    );

    // 4 ns clock
    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        check_count = check_count + 1;
        if (expected !== actual) begin
            error_count = error_count + 1;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // Reference model of one pixel built from the engine rules
    task automatic model_pixel(output logic [15:0] m_bo, output logic [1:0] m_drv);
        logic       is_mono;
        logic [3:0] mode4;
        logic [3:0] dith;
        logic       redraw;
        logic       setmode;
        logic       clr;
        logic [3:0] clear_val;
        logic [3:0] v;
        logic [5:0] cnt;
        logic [1:0] cap;
        logic       prev;
        logic       nv;
        is_mono = proc_bi[15];
        mode4   = proc_bi[15:12];
        // Dither source by mode with unknown mono codes acting as no dither
        if (!is_mono) begin
            dith = proc_bi[14] ? proc_p_e4 : proc_p_or;
        end else if (mode4 == 4'd9) begin
            dith = {4{proc_p_bd}};
        end else if (mode4 == 4'd10) begin
            dith = {4{proc_p_n1}};
        end else begin
            dith = proc_p_or;
        end
        redraw  = op_valid && (op_cmd == 8'h01);
        setmode = op_valid && (op_cmd == 8'h02);
        clr     = redraw || (setmode && (op_framecnt != 8'd0));
        if (!is_mono) begin
            clear_val = 4'd15;
        end else if (op_framecnt[5] || (op_framecnt[4:3] == 2'b11)) begin
            clear_val = 4'd0;
        end else begin
            clear_val = 4'd15;
        end
        v     = clr ? clear_val : dith;
        m_bo  = proc_bi;
        m_drv = 2'b00;
        cnt   = proc_bi[9:4];
        if (!is_mono) begin
            if (cnt != 6'd0) begin
                m_drv      = proc_lut_rd;
                m_bo[9:4]  = cnt - 6'd1;
            end else if (clr) begin
                m_bo[13:10] = proc_bi[3:0];
                m_bo[9:4]   = csr_lutframe;
                m_bo[3:0]   = v;
            end
        end else begin
            cap  = proc_bi[3:2];
            prev = proc_bi[0];
            nv   = v[3];
            if ((cnt != 6'd0) && ((nv == prev) || (cap != 2'd0))) begin
                // Keep driving toward the stored value
                m_drv     = prev ? 2'b10 : 2'b01;
                m_bo[9:4] = cnt - 6'd1;
                m_bo[3:2] = (cap == 2'd0) ? 2'd0 : cap - 2'd1;
            end else if (nv != prev) begin
                m_drv     = nv ? 2'b10 : 2'b01;
                m_bo[9:4] = (cnt != 6'd0) ? (6'd9 - cnt + 6'd1) : 6'd9;
                m_bo[3:2] = csr_mindrv;
                m_bo[0]   = nv;
            end
        end
        if (setmode && (op_framecnt == 8'd0)) begin
            case (op_param)
                8'd1:    m_bo = 16'h400F;
                8'd2:    m_bo = 16'h8001;
                8'd3:    m_bo = 16'h9001;
                8'd4:    m_bo = 16'hA001;
                default: m_bo = 16'h000F;
            endcase
        end
        // Init waveform wins over everything
        if (op_state == 2'd1) begin
            m_bo = 16'h000F;
            if (op_framecnt[4:2] == 3'b111) begin
                m_drv = 2'b00;
            end else if (op_framecnt[5]) begin
                m_drv = 2'b01;
            end else begin
                m_drv = 2'b10;
            end
        end
    endtask

    // Random pixel and controls shaped per test kind
    task automatic drive_pixel(input int kind);
        csr_lutframe = 6'($urandom);
        csr_mindrv   = 2'($urandom);
        proc_p_or    = 4'($urandom);
        proc_p_e4    = 4'($urandom);
        proc_p_bd    = 1'($urandom);
        proc_p_n1    = 1'($urandom);
        proc_bi      = 16'($urandom);
        // LUT readout never carries 11
        proc_lut_rd  = 2'($urandom % 3);
        op_state     = 2'($urandom);
        op_valid     = 1'($urandom);
        op_cmd       = 8'($urandom % 4);
        op_param     = 8'($urandom % 6);
        op_framecnt  = 8'($urandom);
        if (kind != 4 && op_state == `OP_INIT) op_state = 2'd0;
        case (kind)
            1: begin
                proc_bi[15] = 1'b0;
                if ($urandom % 2 == 0) proc_bi[9:4] = 6'd0;
                op_cmd = ($urandom % 2 == 0) ? `OP_EXT_REDRAW : 8'h00;
            end
            2: begin
                // Mostly known mono codes and now and then an unknown one
                if ($urandom % 8 == 0) proc_bi[15:12] = 4'(11 + $urandom % 5);
                else proc_bi[15:12] = 4'(8 + $urandom % 3);
                proc_bi[9:4] = ($urandom % 3 == 0) ? 6'd0 : 6'($urandom % 12);
                op_valid = 1'b0;
            end
            3: begin
                op_valid = 1'b1;
                op_cmd   = ($urandom % 2 == 0) ? `OP_EXT_SETMODE : `OP_EXT_REDRAW;
                if ($urandom % 2 == 0) op_framecnt = 8'd0;
                if ($urandom % 8 == 0) op_param = 8'($urandom);
                if ($urandom % 2 == 0) proc_bi[9:4] = 6'd0;
            end
            4: op_state = `OP_INIT;
            default: begin
                if ($urandom % 4 == 0) op_framecnt = 8'd0;
            end
        endcase
    endtask

    // One pixel per cycle with each result checked one cycle later
    task automatic run_test(input string name, input int kind, input int cycles);
        logic [15:0] m_bo;
        logic [1:0]  m_drv;
        repeat (cycles) begin
            if (pend_valid) begin
                check_value({pend_name, " bo"}, pend_bo, proc_bo);
                check_value({pend_name, " drive"}, {14'd0, pend_drv}, {14'd0, proc_output});
            end
            drive_pixel(kind);
            model_pixel(m_bo, m_drv);
            pend_bo    = m_bo;
            pend_drv   = m_drv;
            pend_name  = name;
            pend_valid = 1'b1;
            @(negedge clk);
        end
    endtask

    initial begin
        void'($urandom(69));
        error_count = 0;
        check_count = 0;
        pend_valid  = 1'b0;
        pend_bo     = 16'd0;
        pend_drv    = 2'd0;
        pend_name   = "";
        reset       = 1'b1;
        drive_pixel(5);
        // Reset must win over random inputs
        repeat (2) begin
            @(negedge clk);
            check_value("reset bo", 16'h000F, proc_bo);
            check_value("reset drive", 16'd0, {14'd0, proc_output});
            drive_pixel(5);
        end
        reset = 1'b0;
        // Reset now low before any edge has seen it
        #1;
        check_value("post_reset bo", 16'h000F, proc_bo);
        check_value("post_reset drive", 16'd0, {14'd0, proc_output});
        // First test pixel goes out on a falling edge
        @(negedge clk);
        run_test("manual_lut", 1, MANUAL_CYCLES);
        run_test("fast_mono", 2, MONO_CYCLES);
        run_test("commands", 3, CMD_CYCLES);
        run_test("init_state", 4, INIT_CYCLES);
        run_test("throughput", 5, THRU_CYCLES);
        check_value({pend_name, " bo"}, pend_bo, proc_bo);
        check_value({pend_name, " drive"}, {14'd0, pend_drv}, {14'd0, proc_output});
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Watchdog sized from the total cycle count plus a margin
    initial begin
        #((TOTAL_CYCLES + 50) * 4);
        $display("Timeout: simulation did not finish in %0d cycles", TOTAL_CYCLES + 50);
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- pixel_processing.sv
// Registered per-pixel update engine wiring source select, LUT and mono engines and merge
`timescale 1ns/1ps
`include "pixel_defs.svh"

module pixel_processing (
    input  logic        clk,
    input  logic        reset,
    // Total frames in the LUT waveform
    input  logic [5:0]  csr_lutframe,
    // Dynamic frame-rate cap setting
    input  logic [1:0]  csr_mindrv,
    // Candidate source pixels
    input  logic [3:0]  proc_p_or,
    input  logic [3:0]  proc_p_e4,
    input  logic        proc_p_bd,
    input  logic        proc_p_n1,
    // State word in from VRAM and LUT readout
    input  logic [15:0] proc_bi,
    input  logic [1:0]  proc_lut_rd,
    // Global operation controls
    input  logic [1:0]  op_state,
    input  logic        op_valid,
    input  logic [7:0]  op_cmd,
    input  logic [7:0]  op_param,
    input  logic [7:0]  op_framecnt,
    // State word back to VRAM and drive code to the panel
    output logic [15:0] proc_bo,
    output logic [1:0]  proc_output
);

    logic [3:0]              vin;
    logic                    lut_start;
    pixel_pkg::pixel_state_u lut_bo;
    pixel_pkg::pixel_state_u mono_bo;
    logic [1:0]              lut_drive;
    logic [1:0]              mono_drive;

    // Forced clear already reaches both engines through vin
    pixel_source_select u_source_select (
        .proc_bi(proc_bi), .proc_p_or(proc_p_or), .proc_p_e4(proc_p_e4),
        .proc_p_bd(proc_p_bd), .proc_p_n1(proc_p_n1), .op_valid(op_valid),
        .op_cmd(op_cmd), .op_framecnt(op_framecnt), .vin(vin),
        .force_clear(), .lut_start(lut_start)
    );

    manual_lut_step u_manual_lut (
        .proc_bi(proc_bi), .vin(vin), .lut_start(lut_start),
        .csr_lutframe(csr_lutframe), .proc_lut_rd(proc_lut_rd),
        .lut_bo(lut_bo), .lut_drive(lut_drive)
    );

    fast_mono_step u_fast_mono (
        .proc_bi(proc_bi), .vin(vin), .csr_mindrv(csr_mindrv),
        .mono_bo(mono_bo), .mono_drive(mono_drive)
    );

    pixel_state_merge u_merge (
        .clk(clk), .reset(reset), .proc_bi(proc_bi), .op_state(op_state),
        .op_valid(op_valid), .op_cmd(op_cmd), .op_param(op_param),
        .op_framecnt(op_framecnt), .lut_bo(lut_bo), .lut_drive(lut_drive),
        .mono_bo(mono_bo), .mono_drive(mono_drive),
        .proc_bo(proc_bo), .proc_output(proc_output)
    );

endmodule

//--- pixel_state_merge.sv
// Engine select, set-mode and init overrides, and the output register
`timescale 1ns/1ps
`include "pixel_defs.svh"

module pixel_state_merge (
    input  logic        clk,
    input  logic        reset,
    input  logic [15:0] proc_bi,
    input  logic [1:0]  op_state,
    input  logic        op_valid,
    input  logic [7:0]  op_cmd,
    input  logic [7:0]  op_param,
    input  logic [7:0]  op_framecnt,
    input  logic [15:0] lut_bo,
    input  logic [1:0]  lut_drive,
    input  logic [15:0] mono_bo,
    input  logic [1:0]  mono_drive,
    output logic [15:0] proc_bo,
    output logic [1:0]  proc_output
);

    pixel_pkg::pixel_state_u state;
    pixel_pkg::base_mode_e   base_mode;
    logic                    setmode_apply;
    logic [15:0]             next_bo;
    logic [1:0]              next_drive;

    assign state = proc_bi;

    // Bit 15 splits LUT modes from mono modes
    assign base_mode = state.lut.mode_prefix[1] ? pixel_pkg::BASE_FAST_MONO
                                                : pixel_pkg::BASE_MANUAL_LUT;

    // Mode switch only takes effect once the global count is idle
    assign setmode_apply = op_valid && (op_cmd == `OP_EXT_SETMODE) && (op_framecnt == 8'd0);

    always_comb begin
        // Normal engine result
        if (base_mode == pixel_pkg::BASE_MANUAL_LUT) begin
            next_bo    = lut_bo;
            next_drive = lut_drive;
        end else begin
            next_bo    = mono_bo;
            next_drive = mono_drive;
        end

        // Set-mode loads the starting word and leaves the drive alone
        if (setmode_apply) begin
            case (op_param)
                `SETMODE_MANUAL_LUT_NO_DITHER:
                    next_bo = {`MODE_MANUAL_LUT_NO_DITHER, 4'd0, 6'd0, 4'd15};
                `SETMODE_MANUAL_LUT_ERROR_DIFFUSION:
                    next_bo = {`MODE_MANUAL_LUT_ERROR_DIFFUSION, 4'd0, 6'd0, 4'd15};
                `SETMODE_FAST_MONO_NO_DITHER:  next_bo = `INIT_FAST_MONO_ND;
                `SETMODE_FAST_MONO_BAYER:      next_bo = `INIT_FAST_MONO_BD;
                `SETMODE_FAST_MONO_BLUE_NOISE: next_bo = `INIT_FAST_MONO_BN;
                // Bad parameter falls back to plain manual LUT
                default: next_bo = {`MODE_MANUAL_LUT_NO_DITHER, 4'd0, 6'd0, 4'd15};
            endcase
        end

        // Init waveform overrides everything
        if (op_state == `OP_INIT) begin
            // Down-counting frames x111xx give no drive, 1xxxxx black and all others white
            if (op_framecnt[4:2] == 3'b111) begin
                next_drive = `NO_DRIVE;
            end else if (op_framecnt[5]) begin
                next_drive = `DRIVE_BLACK;
            end else begin
                next_drive = `DRIVE_WHITE;
            end
            next_bo = `DEFAULT_MODE;
        end
    end

    // One cycle from sampled pixel to VRAM and panel
    always_ff @(posedge clk) begin
        if (reset) begin
            proc_bo     <= `DEFAULT_MODE;
            proc_output <= `NO_DRIVE;
        end else begin
            proc_bo     <= next_bo;
            proc_output <= next_drive;
        end
    end

    // No engine or override ever drives both rails
    assert property (@(posedge clk) disable iff (reset) proc_output != 2'b11)
        else $error("illegal drive code on proc_output");

endmodule

//--- fast_mono_step.sv
// Next state word and drive code for a pixel in fast mono mode with frame-rate cap
`timescale 1ns/1ps
`include "pixel_defs.svh"

module fast_mono_step (
    input  logic [15:0] proc_bi,
    input  logic [3:0]  vin,
    input  logic [1:0]  csr_mindrv,
    output logic [15:0] mono_bo,
    output logic [1:0]  mono_drive
);

    pixel_pkg::pixel_state_u state;
    pixel_pkg::pixel_state_u next_state;
    logic                    new_val;
    logic                    changed;
    logic [5:0]              full_frames;
    logic [1:0]              cap_dec;
    logic [1:0]              drive_to_input;
    logic [1:0]              drive_to_prev;

    assign state = proc_bi;

    // Mono only looks at the MSB of the input
    assign new_val = vin[3];
    assign changed = (new_val != state.mono.prev);

    // Full swing length in the new direction
    assign full_frames = new_val ? `FASTM_B2W_FRAMES : `FASTM_W2B_FRAMES;

    // Cap counts down and stops at zero
    assign cap_dec = (state.mono.cap != 2'd0) ? (state.mono.cap - 2'd1) : 2'd0;

    assign drive_to_input = new_val ? `DRIVE_WHITE : `DRIVE_BLACK;
    assign drive_to_prev  = state.mono.prev ? `DRIVE_WHITE : `DRIVE_BLACK;

    always_comb begin
        next_state = state;
        if (state.mono.framecnt != 6'd0) begin
            if (changed && (state.mono.cap == 2'd0)) begin
                // Reversal mid-update
                // undo only the frames already spent
                mono_drive = drive_to_input;
                next_state.mono.framecnt = full_frames - state.mono.framecnt + 6'd1;
                next_state.mono.cap      = csr_mindrv;
                next_state.mono.prev     = new_val;
            end else begin
                // Keep pushing toward the stored value
                mono_drive = drive_to_prev;
                next_state.mono.framecnt = state.mono.framecnt - 6'd1;
                next_state.mono.cap      = cap_dec;
            end
        end else if (changed) begin
            // Fresh update from a settled pixel
            mono_drive = drive_to_input;
            next_state.mono.framecnt = full_frames;
            next_state.mono.cap      = csr_mindrv;
            next_state.mono.prev     = new_val;
        end else begin
            mono_drive = `NO_DRIVE;
        end
    end

    assign mono_bo = next_state;

endmodule

//--- manual_lut_step.sv
// Next state word and drive code for a pixel in manual waveform-LUT mode
`timescale 1ns/1ps
`include "pixel_defs.svh"

module manual_lut_step (
    input  logic [15:0] proc_bi,
    input  logic [3:0]  vin,
    input  logic        lut_start,
    input  logic [5:0]  csr_lutframe,
    input  logic [1:0]  proc_lut_rd,
    output logic [15:0] lut_bo,
    output logic [1:0]  lut_drive
);

    pixel_pkg::pixel_state_u state;
    pixel_pkg::pixel_state_u next_state;

    assign state = proc_bi;

    always_comb begin
        next_state = state;
        if (state.lut.framecnt != 6'd0) begin
            // Waveform running, source and target frozen
            lut_drive = proc_lut_rd;
            next_state.lut.framecnt = state.lut.framecnt - 6'd1;
        end else begin
            // Idle pixel
            lut_drive = `NO_DRIVE;
            if (lut_start) begin
                // Current screen value becomes the waveform source
                next_state.lut.src      = state.lut.target;
                next_state.lut.framecnt = csr_lutframe;
                next_state.lut.target   = vin;
            end
        end
    end

    assign lut_bo = next_state;

endmodule

//--- pixel_source_select.sv
// Dither decode, effective input value and forced clear for one pixel
`timescale 1ns/1ps
`include "pixel_defs.svh"

module pixel_source_select (
    input  logic [15:0] proc_bi,
    input  logic [3:0]  proc_p_or,
    input  logic [3:0]  proc_p_e4,
    input  logic        proc_p_bd,
    input  logic        proc_p_n1,
    input  logic        op_valid,
    input  logic [7:0]  op_cmd,
    input  logic [7:0]  op_framecnt,
    output logic [3:0]  vin,
    output logic        force_clear,
    output logic        lut_start
);

    pixel_pkg::pixel_state_u state;
    pixel_pkg::base_mode_e   base_mode;
    logic [3:0]              dither_in;
    logic [3:0]              clear_color;
    logic                    redraw_cmd;
    logic                    setmode_cmd;

    assign state = proc_bi;

    // Command decode
    assign redraw_cmd  = op_valid && (op_cmd == `OP_EXT_REDRAW);
    assign setmode_cmd = op_valid && (op_cmd == `OP_EXT_SETMODE);

    // Set-mode during a running global count clears the pixel first
    assign force_clear = redraw_cmd || (setmode_cmd && (op_framecnt != 8'd0));
    assign lut_start   = redraw_cmd || force_clear;

    // Mode decode picks the dithered source
    always_comb begin
        case (state.lut.mode_prefix)
            `MODE_MANUAL_LUT_NO_DITHER: begin
                base_mode = pixel_pkg::BASE_MANUAL_LUT;
                dither_in = proc_p_or;
            end
            `MODE_MANUAL_LUT_ERROR_DIFFUSION: begin
                base_mode = pixel_pkg::BASE_MANUAL_LUT;
                dither_in = proc_p_e4;
            end
            default: begin
                base_mode = pixel_pkg::BASE_FAST_MONO;
                case (state.mono.mode)
                    `MODE_FAST_MONO_NO_DITHER:  dither_in = proc_p_or;
                    // 1-bit dithers stretched to the 4-bit input
                    `MODE_FAST_MONO_BAYER:      dither_in = {4{proc_p_bd}};
                    `MODE_FAST_MONO_BLUE_NOISE: dither_in = {4{proc_p_n1}};
                    // Unknown codes behave as mono without dither
                    default:                    dither_in = proc_p_or;
                endcase
            end
        endcase
    end

    // LUT pixels clear to white
    // Mono pixels follow the phase of the global count
    always_comb begin
        if (base_mode == pixel_pkg::BASE_MANUAL_LUT) begin
            clear_color = 4'hF;
        end else if ((op_framecnt[4:3] == 2'b11) || op_framecnt[5]) begin
            clear_color = 4'h0;
        end else begin
            clear_color = 4'hF;
        end
    end

    assign vin = force_clear ? clear_color : dither_in;

endmodule

//--- pixel_pkg.sv
// Pixel state word views, the packed union over them and the base-mode type
package pixel_pkg;

    // Manual LUT layout of the state word
    typedef struct packed {
        // Only the top two mode bits are decoded here
        logic [1:0] mode_prefix;
        // Screen value before the running update
        logic [3:0] src;
        // Frames left in the waveform, zero when idle
        logic [5:0] framecnt;
        // Value the pixel is being driven to
        logic [3:0] target;
    } lut_view_t;

    // Fast mono layout of the same word
    typedef struct packed {
        logic [3:0] mode;
        // Kept at zero
        logic [1:0] rsvd_hi;
        // Frames left in the mono drive
        logic [5:0] framecnt;
        // Dynamic frame-rate cap, a new value waits for zero
        logic [1:0] cap;
        // Kept at zero
        logic       rsvd_lo;
        // Last value driven, 1 is white
        logic       prev;
    } mono_view_t;

    // One VRAM word, decoded by the mode it carries
    typedef union packed {
        lut_view_t  lut;
        mono_view_t mono;
    } pixel_state_u;

    // Engine that owns a pixel, from mode bit 15
    typedef enum logic {
        BASE_MANUAL_LUT = 1'b0,
        BASE_FAST_MONO  = 1'b1
    } base_mode_e;

endpackage

//--- pixel_defs.svh
// Command codes, operating state, set-mode codes, frame counts, drive codes and initial state words
`ifndef PIXEL_DEFS_SVH
`define PIXEL_DEFS_SVH

// External operation commands
`define OP_EXT_REDRAW  8'h01
`define OP_EXT_SETMODE 8'h02

// Global operating state that runs the panel init waveform
`define OP_INIT 2'd1

// Parameter codes carried by a set-mode command
`define SETMODE_MANUAL_LUT_NO_DITHER       8'd0
`define SETMODE_MANUAL_LUT_ERROR_DIFFUSION 8'd1
`define SETMODE_FAST_MONO_NO_DITHER        8'd2
`define SETMODE_FAST_MONO_BAYER            8'd3
`define SETMODE_FAST_MONO_BLUE_NOISE       8'd4

// Full-swing frame counts in fast mono mode
`define FASTM_B2W_FRAMES 6'd9
`define FASTM_W2B_FRAMES 6'd9

// Panel drive codes, 11 is never sent
`define NO_DRIVE    2'b00
`define DRIVE_BLACK 2'b01
`define DRIVE_WHITE 2'b10

// Mode field encodings, manual LUT only decodes the top two bits
`define MODE_MANUAL_LUT_NO_DITHER       2'd0
`define MODE_MANUAL_LUT_ERROR_DIFFUSION 2'd1
`define MODE_FAST_MONO_NO_DITHER        4'd8
`define MODE_FAST_MONO_BAYER            4'd9
`define MODE_FAST_MONO_BLUE_NOISE       4'd10

// Manual LUT without dither, idle, screen assumed white
`define DEFAULT_MODE {`MODE_MANUAL_LUT_NO_DITHER, 4'd0, 6'd0, 4'd15}

// Fast mono starting words: idle, no cap, previous value white
`define INIT_FAST_MONO_ND {`MODE_FAST_MONO_NO_DITHER, 2'b00, 6'd0, 2'd0, 1'b0, 1'b1}
`define INIT_FAST_MONO_BD {`MODE_FAST_MONO_BAYER, 2'b00, 6'd0, 2'd0, 1'b0, 1'b1}
`define INIT_FAST_MONO_BN {`MODE_FAST_MONO_BLUE_NOISE, 2'b00, 6'd0, 2'd0, 1'b0, 1'b1}

`endif
